//--- Bender.yml
package:
  name: cpuCore

sources:
  - verilog/cpuPkg.sv
  - verilog/cpuIfs.sv
  - verilog/instrSequencer.sv
  - verilog/regFile.sv
  - verilog/execUnit.sv
  - verilog/cpuCore.sv
  - target: test
    files:
      - tests/cpuChecker.sv
      - tests/tbCpu.sv

//--- tb.f
verilog/cpuPkg.sv
verilog/cpuIfs.sv
verilog/instrSequencer.sv
verilog/regFile.sv
verilog/execUnit.sv
verilog/cpuCore.sv
tests/cpuChecker.sv
tests/tbCpu.sv

//--- tests/cpuCases.txt
# Tokens in hex: case <haltAddr>, at <byteAddr> then RAM words, dout then DoutR values,
# wr then address/data pairs of RAM writes, end runs the case; # starts a note line
case 54
at 0 00000201 00000005 00000301 fffffffe 03020411 00000419 00020514 00000007
00000519 00000515 00000216 00000601 00000003 06050717 00000719 02070818
00000819 00020912 00000010 00090a02 00000a19 0000001a
dout 3 fffffffe fffffff8 0fffffff 14
end
case 50
at 0 00000201 12345678 00020005 00000100 00000303 00000100 00000319 00000401
00000080 00040504 00000519 00000001 00000200 00000306 00000506 00000607
00000707 00000619 00000719 00000019 0000001a
at 80 cafef00d
dout 12345678 cafef00d cafef00d 12345678 200
wr 100 12345678 200 12345678 204 cafef00d
end
case 24
at 0 00000001 00000300 00000201 00000040 00000301 00000011 00000208 00000319
00000019 0000001a
at 40 03030311 00000019 00000009
dout 304 22 300
wr 300 18
end
case a4
at 0 00000201 00000007 00000301 00000007 00000401 000000aa 00000501 00000055
0003020a 0000000d 00000030 00000419 00000519 0000000e 00000040 00000219
0000020b 00000009 0000000d 00000054 00000119 0000000e 00000060 00000419
00000601 00000000 0600000f 00000074 00000419 06000010 00000080 00000519
02000010 0000008c 00000419 0000000c 00000098 00000419 0000020b 00000003
00000119 0000001a
dout 55 7 2 55 4
end

//--- tests/cpuChecker.sv
`timescale 1ns/100ps

module cpuChecker (
  input logic         clk,
  input logic         reset,
  input logic         readReq,
  input logic         writeReq,
  input cpuPkg::wordT ramAddress,
  input cpuPkg::wordT ramOut,
  input cpuPkg::wordT instrPtr,
  input logic         debugValid,
  input cpuPkg::wordT debugValue
);
  import cpuPkg::*;

  wordT doutQ [$];            // Expected DoutR values, in order
  wordT wrAddrQ [$];          // Expected RAM writes
  wordT wrDataQ [$];
  int   valueErrors = 0;
  int   extraOutputs = 0;     // Outputs with nothing left to match
  logic resetSeen = 1'b0;
  logic firstFetch = 1'b0;

  task automatic clearExpected();
    doutQ.delete();
    wrAddrQ.delete();
    wrDataQ.delete();
  endtask

  task automatic expectDout(input wordT value);
    doutQ.push_back(value);
  endtask

  task automatic expectWrite(input wordT addr, input wordT data);
    wrAddrQ.push_back(addr);
    wrDataQ.push_back(data);
  endtask

  // Outputs still owed by the running case
  function automatic int remaining();
    return doutQ.size() + wrAddrQ.size();
  endfunction

  task automatic checkValue(input string name, input wordT expected, input wordT actual);
    if (actual !== expected) begin
      valueErrors++;
      $display("** Error: %s expected 0x%h, got 0x%h at %0t", name, expected, actual, $time);
    end
  endtask

  // Falling edge, all DUT outputs settled
  always @(negedge clk) begin
    if (reset) begin
      resetSeen  = 1'b1;
      firstFetch = 1'b1;
    end else begin
      if (resetSeen) begin           // First cycle out of reset
        checkValue("readReq", '0, readReq);
        checkValue("writeReq", '0, writeReq);
        checkValue("instrPtr", '0, instrPtr);
        resetSeen = 1'b0;
      end
      if (readReq && firstFetch) begin
        checkValue("ramAddress", '0, ramAddress);   // Fetch starts at 0
        firstFetch = 1'b0;
      end
      if (writeReq) begin
        if (wrAddrQ.size() == 0) begin
          extraOutputs++;
          $display("Unexpected RAM write of 0x%h to 0x%h at %0t", ramOut, ramAddress, $time);
        end else begin
          checkValue("ramAddress", wrAddrQ.pop_front(), ramAddress);
          checkValue("ramOut", wrDataQ.pop_front(), ramOut);
        end
      end
      if (debugValid) begin
        if (doutQ.size() == 0) begin
          extraOutputs++;
          $display("Unexpected debug output 0x%h at %0t", debugValue, $time);
        end else begin
          checkValue("debugValue", doutQ.pop_front(), debugValue);
        end
      end
    end
  end

endmodule

//--- tests/tbCpu.sv
`timescale 1ns/100ps

module tbCpu;
  import cpuPkg::*;

  localparam time driveDelay = 10ns;   // After the rising edge
  localparam int  memWords   = 256;    // 1 KB of RAM
  localparam int  runLimit   = 20000;  // Cycles per case

  logic clk, reset, readReq, writeReq, readAck, writeAck, debugValid;
  wordT ramIn, ramAddress, ramOut, instrPtr, debugValue;
  wordT mem [memWords];

  logic busy, isWrite;                 // Memory model state
  wordT reqAddr;
  int   ackDelay;
  int   seed = 79861;
  int   failures = 0;                  // Timeouts and file problems

  cpuCore i_cpuCore (
    .clk(clk), .reset(reset), .ramIn(ramIn), .readAck(readAck), .writeAck(writeAck),
    .ramAddress(ramAddress), .ramOut(ramOut), .readReq(readReq), .writeReq(writeReq),
    .instrPtr(instrPtr), .debugValid(debugValid), .debugValue(debugValue)
  );

  cpuChecker i_cpuChecker (
    .clk(clk), .reset(reset), .readReq(readReq), .writeReq(writeReq),
    .ramAddress(ramAddress), .ramOut(ramOut), .instrPtr(instrPtr),
    .debugValid(debugValid), .debugValue(debugValue)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // RAM answers each request after 0 to 4 idle cycles
  initial begin
    void'($urandom(seed));
    readAck  = 1'b0;
    writeAck = 1'b0;
    ramIn    = '0;
    busy     = 1'b0;
    forever begin
      @(posedge clk);
      #driveDelay;
      readAck  = 1'b0;                 // Acks last one cycle
      writeAck = 1'b0;
      if (reset) begin
        busy = 1'b0;
      end else if (busy) begin
        if (ackDelay == 0) begin
          busy = 1'b0;
          if (isWrite) begin
            writeAck = 1'b1;
          end else begin
            ramIn   = mem[reqAddr[9:2]];
            readAck = 1'b1;
          end
        end else begin
          ackDelay--;
        end
      end else if (readReq || writeReq) begin
        busy     = 1'b1;
        isWrite  = writeReq;
        reqAddr  = ramAddress;
        ackDelay = $urandom % 5;
        if (writeReq) mem[ramAddress[9:2]] = ramOut;
      end
    end
  end

  task automatic startCase();
    reset = 1'b1;                      // Held through loading
    for (int i = 0; i < memWords; i++) begin
      mem[i] = 32'hc0de0000 | i;       // Unwritten words show their index
    end
    i_cpuChecker.clearExpected();
  endtask

  task automatic runCase(input int pass, input int caseNum, input wordT haltAddr);
    int cycles;
    cycles = 0;
    repeat (3) @(posedge clk);
    #driveDelay reset = 1'b0;
    // Done once parked on Stall with every output seen
    while (!(instrPtr == haltAddr && i_cpuChecker.remaining() == 0) && cycles < runLimit) begin
      @(posedge clk);
      #driveDelay;
      cycles++;
    end
    if (cycles >= runLimit) begin
      failures++;
      $display("Pass %0d case %0d timed out before reaching its halt address with all outputs",
               pass, caseNum);
    end
  endtask

  // Token stream, see the notes at the top of the cases file
  task automatic readCases(input int pass);
    int           fd, mode, caseNum;
    string        tok;
    wordT         value, loadAddr, haltAddr, pendAddr;
    logic         addrHeld;
    logic [799:0] skipLine;
    caseNum  = 0;
    mode     = 0;
    addrHeld = 1'b0;
    loadAddr = '0;
    haltAddr = '0;
    fd = $fopen("tests/cpuCases.txt", "r");
    if (fd == 0) begin
      failures++;
      $display("Could not open tests/cpuCases.txt");
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok.getc(0) == "#") begin
          void'($fgets(skipLine, fd));
        end else if (tok == "case") begin
          void'($fscanf(fd, "%h", haltAddr));
          caseNum++;
          startCase();
        end else if (tok == "at") begin
          void'($fscanf(fd, "%h", loadAddr));
          mode = 0;
        end else if (tok == "dout") begin
          mode = 1;
        end else if (tok == "wr") begin
          mode     = 2;
          addrHeld = 1'b0;
        end else if (tok == "end") begin
          runCase(pass, caseNum, haltAddr);
        end else begin
          void'($sscanf(tok, "%h", value));
          if (mode == 0) begin
            mem[loadAddr[9:2]] = value;
            loadAddr += 4;
          end else if (mode == 1) begin
            i_cpuChecker.expectDout(value);
          end else if (!addrHeld) begin
            pendAddr = value;          // Address half of a pair
            addrHeld = 1'b1;
          end else begin
            i_cpuChecker.expectWrite(pendAddr, value);
            addrHeld = 1'b0;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    reset = 1'b1;
    // Second pass reruns every case with other ack delays
    for (int pass = 1; pass <= 2; pass++) begin
      readCases(pass);
    end
    $display("Error counts: %0d wrong values, %0d unexpected outputs, %0d other failures",
             i_cpuChecker.valueErrors, i_cpuChecker.extraOutputs, failures);
    if (i_cpuChecker.valueErrors + i_cpuChecker.extraOutputs + failures == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- verilog/cpuCore.sv
`timescale 1ns/100ps

module cpuCore (
  input  logic         clk,
  input  logic         reset,
  input  cpuPkg::wordT ramIn,
  input  logic         readAck,
  input  logic         writeAck,
  output cpuPkg::wordT ramAddress,
  output cpuPkg::wordT ramOut,
  output logic         readReq,
  output logic         writeReq,
  output cpuPkg::wordT instrPtr,
  output logic         debugValid,
  output cpuPkg::wordT debugValue
);

  instrIf instrBus ();   // Sequencer to execute
  regIf   regBus ();     // Register file access

  // Fetch, decode, operands and RAM traffic
  instrSequencer i_instrSequencer (
    .clk        (clk),
    .reset      (reset),
    .ramIn      (ramIn),
    .readAck    (readAck),
    .writeAck   (writeAck),
    .ramAddress (ramAddress),
    .ramOut     (ramOut),
    .readReq    (readReq),
    .writeReq   (writeReq),
    .instrPtr   (instrPtr),
    .instr      (instrBus.seq),
    .regs       (regBus.reader)
  );

  regFile i_regFile (
    .clk   (clk),
    .reset (reset),
    .regs  (regBus.store)
  );

  // Writeback, jumps and debug strobe
  execUnit i_execUnit (
    .clk        (clk),
    .reset      (reset),
    .instr      (instrBus.exec),
    .regs       (regBus.writer),
    .debugValid (debugValid),
    .debugValue (debugValue)
  );

endmodule

//--- verilog/cpuIfs.sv
`timescale 1ns/100ps

// Decoded instruction from sequencer to execute unit, results back
interface instrIf;
  import cpuPkg::*;

  logic    execStrobe;
  opCodeT  opCode;
  regAddrT dstAddr;     // Field A
  wordT    opA;
  wordT    opB;
  wordT    opC;
  wordT    dataWord;    // Constant of long ops
  wordT    ramValue;    // Data read result
  wordT    instrPtr;
  logic    execDone;
  logic    jumpTaken;
  wordT    jumpTarget;

  modport seq (output execStrobe, opCode, dstAddr, opA, opB, opC, dataWord, ramValue,
               instrPtr, input execDone, jumpTaken, jumpTarget);
  modport exec (input execStrobe, opCode, dstAddr, opA, opB, opC, dataWord, ramValue,
                instrPtr, output execDone, jumpTaken, jumpTarget);
endinterface

// Register file access, reads for the sequencer, writes for execute
interface regIf;
  import cpuPkg::*;

  regAddrT rdAddrA, rdAddrB, rdAddrC;
  wordT    rdDataA, rdDataB, rdDataC;
  wordT    spValue;
  logic    wrEn;
  regAddrT wrAddr;
  wordT    wrData;
  logic    spWrEn;      // Has priority on register 0
  wordT    spData;

  modport store (input rdAddrA, rdAddrB, rdAddrC, wrEn, wrAddr, wrData, spWrEn, spData,
                 output rdDataA, rdDataB, rdDataC, spValue);
  modport reader (output rdAddrA, rdAddrB, rdAddrC, input rdDataA, rdDataB, rdDataC, spValue);
  modport writer (output wrEn, wrAddr, wrData, spWrEn, spData, input spValue);
endinterface

//--- verilog/cpuPkg.sv
package cpuPkg;

  // Datapath sizes
  localparam int wordWidth    = 32;
  localparam int opCodeWidth  = 8;
  localparam int regCount     = 64;
  localparam int regAddrWidth = $clog2(regCount);  // 6 index bits

  typedef logic [wordWidth-1:0]    wordT;
  typedef logic [regAddrWidth-1:0] regAddrT;

  // Registers with a fixed role
  localparam regAddrT spReg   = regAddrT'(0);  // Stack pointer
  localparam regAddrT flagReg = regAddrT'(1);  // Compare flags

  // Bit positions inside flagReg
  localparam int flagEq = 0;
  localparam int flagLt = 1;
  localparam int flagGt = 2;

  localparam wordT stackStep = wordT'(4);  // Bytes per stack slot

  // Opcode byte, bits 7:0 of the first instruction word
  typedef enum logic [opCodeWidth-1:0] {
    MovRC  = 8'h01,
    MovRR  = 8'h02,
    MovRdC = 8'h03,
    MovRdR = 8'h04,
    MovdCR = 8'h05,
    PushR  = 8'h06,
    PopR   = 8'h07,
    CallR  = 8'h08,
    Ret    = 8'h09,
    CmpRR  = 8'h0a,
    CmpRC  = 8'h0b,
    JmpC   = 8'h0c,
    JeC    = 8'h0d,
    JneC   = 8'h0e,
    JzRC   = 8'h0f,
    JnzRC  = 8'h10,
    AddRRR = 8'h11,
    AddRRC = 8'h12,
    SubRRR = 8'h13,
    SubRRC = 8'h14,
    IncR   = 8'h15,
    DecR   = 8'h16,
    ShlRRR = 8'h17,
    ShrRRR = 8'h18,
    DoutR  = 8'h19,
    Stall  = 8'h1a
  } opCodeT;

  typedef enum logic [1:0] {memNone, memRead, memWrite} memAccessT;

  // 8-byte instructions, constant word at ip + 4
  function automatic logic isLongOp(input opCodeT op);
    return op inside {MovRC, MovRdC, MovdCR, CmpRC, AddRRC, SubRRC, JmpC, JeC, JneC, JzRC, JnzRC};
  endfunction

  function automatic memAccessT memAccessOf(input opCodeT op);
    memAccessT access;
    case (op)
      MovRdC, MovRdR, PopR, Ret: access = memRead;
      MovdCR, PushR, CallR:      access = memWrite;
      default:                   access = memNone;
    endcase
    return access;
  endfunction

endpackage

//--- verilog/execUnit.sv
`timescale 1ns/100ps

module execUnit (
  input  logic         clk,
  input  logic         reset,
  instrIf.exec         instr,
  regIf.writer         regs,
  output logic         debugValid,
  output cpuPkg::wordT debugValue
);
  import cpuPkg::*;

  logic    wrNeeded, spNeeded, taken, dout;
  regAddrT resultAddr;
  wordT    result, spNext, target;

  // Unsigned compare into the three flag bits
  function automatic wordT compareFlags(input wordT lhs, input wordT rhs);
    wordT flags;
    flags         = '0;
    flags[flagEq] = (lhs == rhs);
    flags[flagLt] = (lhs < rhs);
    flags[flagGt] = (lhs > rhs);
    return flags;
  endfunction

  always_comb begin
    wrNeeded   = 1'b0;
    spNeeded   = 1'b0;
    taken      = 1'b0;
    dout       = 1'b0;
    resultAddr = instr.dstAddr;
    result     = instr.ramValue;           // Loads and pops
    spNext     = regs.spValue + stackStep;
    target     = instr.dataWord;           // Constant jump address
    case (instr.opCode)
      MovRC: begin
        wrNeeded = 1'b1;
        result   = instr.dataWord;
      end
      MovRR: begin
        wrNeeded = 1'b1;
        result   = instr.opB;
      end
      MovRdC, MovRdR: wrNeeded = 1'b1;
      PushR:          spNeeded = 1'b1;
      PopR: begin
        wrNeeded = 1'b1;
        spNeeded = 1'b1;
        spNext   = regs.spValue - stackStep;
      end
      CallR: begin
        spNeeded = 1'b1;
        taken    = 1'b1;
        target   = instr.opA;
      end
      Ret: begin
        spNeeded = 1'b1;
        spNext   = regs.spValue - stackStep;
        taken    = 1'b1;
        target   = instr.ramValue + 4;     // Skip the CallR
      end
      CmpRR: begin
        wrNeeded   = 1'b1;
        resultAddr = flagReg;
        result     = compareFlags(instr.opA, instr.opB);
      end
      CmpRC: begin
        wrNeeded   = 1'b1;
        resultAddr = flagReg;
        result     = compareFlags(instr.opA, instr.dataWord);
      end
      JmpC:   taken = 1'b1;
      JeC:    taken = instr.opA[flagEq];   // opA holds flagReg here
      JneC:   taken = !instr.opA[flagEq];
      JzRC:   taken = (instr.opC == '0);
      JnzRC:  taken = (instr.opC != '0);
      AddRRR: begin
        wrNeeded = 1'b1;
        result   = instr.opB + instr.opC;
      end
      AddRRC: begin
        wrNeeded = 1'b1;
        result   = instr.opB + instr.dataWord;
      end
      SubRRR: begin
        wrNeeded = 1'b1;
        result   = instr.opB - instr.opC;
      end
      SubRRC: begin
        wrNeeded = 1'b1;
        result   = instr.opB - instr.dataWord;
      end
      IncR: begin
        wrNeeded = 1'b1;
        result   = instr.opA + 1;
      end
      DecR: begin
        wrNeeded = 1'b1;
        result   = instr.opA - 1;
      end
      ShlRRR: begin
        wrNeeded = 1'b1;
        result   = instr.opB << instr.opC;
      end
      ShrRRR: begin
        wrNeeded = 1'b1;
        result   = instr.opB >> instr.opC;
      end
      DoutR:  dout = 1'b1;
      Stall: begin
        taken  = 1'b1;                     // Spins on itself
        target = instr.instrPtr;
      end
      default: ;                           // Unknown opcode is a no-op
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      instr.execDone  <= 1'b0;
      instr.jumpTaken <= 1'b0;
      regs.wrEn       <= 1'b0;
      regs.spWrEn     <= 1'b0;
      debugValid      <= 1'b0;
    end else begin
      instr.execDone  <= instr.execStrobe;   // Always one cycle later
      instr.jumpTaken <= instr.execStrobe && taken;
      regs.wrEn       <= instr.execStrobe && wrNeeded;
      regs.spWrEn     <= instr.execStrobe && spNeeded;
      debugValid      <= instr.execStrobe && dout;
      if (instr.execStrobe) begin
        instr.jumpTarget <= target;
        regs.wrAddr      <= resultAddr;
        regs.wrData      <= result;
        regs.spData      <= spNext;
        debugValue       <= instr.opA;
      end
    end
  end

  // Handshake with the sequencer, one strobe per result
  doneAfterStrobe: assert property (@(posedge clk) disable iff (reset)
    instr.execStrobe |=> instr.execDone && !instr.execStrobe);
  // Decoded opcode settled when execution starts
  opKnownAtStrobe: assert property (@(posedge clk) disable iff (reset)
    instr.execStrobe |-> !$isunknown(instr.opCode));

endmodule

//--- verilog/instrSequencer.sv
`timescale 1ns/100ps

module instrSequencer (
  input  logic         clk,
  input  logic         reset,
  input  cpuPkg::wordT ramIn,
  input  logic         readAck,
  input  logic         writeAck,
  output cpuPkg::wordT ramAddress,
  output cpuPkg::wordT ramOut,
  output logic         readReq,
  output logic         writeReq,
  output cpuPkg::wordT instrPtr,
  instrIf.seq          instr,
  regIf.reader         regs
);
  import cpuPkg::*;

  typedef enum logic [3:0] {
    stFetch, stFetchWait, stOperand, stConstWait, stDataReq, stDataWait,
    stExec, stExecWait, stUpdate
  } seqStateT;

  seqStateT  state;
  regAddrT   fieldA, fieldB, fieldC;
  logic      longOp;
  memAccessT access;
  logic      jumpPending;   // Latched jump decision
  wordT      jumpAddr;

  assign longOp = isLongOp(instr.opCode);
  assign access = memAccessOf(instr.opCode);

  // Flag jumps test flagReg through operand A
  assign regs.rdAddrA = (instr.opCode inside {JeC, JneC}) ? flagReg : fieldA;
  assign regs.rdAddrB = fieldB;
  assign regs.rdAddrC = fieldC;
  assign instr.dstAddr  = fieldA;
  assign instr.instrPtr = instrPtr;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state            <= stFetch;
      readReq          <= 1'b0;
      writeReq         <= 1'b0;
      instrPtr         <= '0;
      instr.execStrobe <= 1'b0;
    end else begin
      case (state)
        stFetch: begin
          readReq    <= 1'b1;
          ramAddress <= instrPtr;
          state      <= stFetchWait;
        end
        stFetchWait: begin
          readReq <= 1'b0;
          if (readAck && !readReq) begin   // Ack only after the request cycle
            instr.opCode <= opCodeT'(ramIn[7:0]);
            fieldA       <= ramIn[13:8];     // Low six bits of each field
            fieldB       <= ramIn[21:16];
            fieldC       <= ramIn[29:24];
            state        <= stOperand;
          end
        end
        stOperand: begin
          instr.opA <= regs.rdDataA;
          instr.opB <= regs.rdDataB;
          instr.opC <= regs.rdDataC;
          if (longOp) begin
            readReq    <= 1'b1;
            ramAddress <= instrPtr + 4;    // Constant word
            state      <= stConstWait;
          end else if (access != memNone) begin
            state <= stDataReq;
          end else begin
            state <= stExec;
          end
        end
        stConstWait: begin
          readReq <= 1'b0;
          if (readAck && !readReq) begin
            instr.dataWord <= ramIn;
            state          <= (access != memNone) ? stDataReq : stExec;
          end
        end
        stDataReq: begin
          case (instr.opCode)
            MovRdC, MovdCR: ramAddress <= instr.dataWord;
            MovRdR:         ramAddress <= instr.opB;
            PushR, CallR:   ramAddress <= regs.spValue;               // Stack grows up
            default:        ramAddress <= regs.spValue - stackStep;   // PopR, Ret
          endcase
          // Store data, return address for CallR
          ramOut   <= (instr.opCode == MovdCR) ? instr.opB :
                      (instr.opCode == PushR) ? instr.opA : instrPtr;
          readReq  <= (access == memRead);
          writeReq <= (access == memWrite);
          state    <= stDataWait;
        end
        stDataWait: begin
          readReq  <= 1'b0;
          writeReq <= 1'b0;
          if (access == memRead && readAck && !readReq) begin
            instr.ramValue <= ramIn;
            state          <= stExec;
          end else if (access == memWrite && writeAck && !writeReq) begin
            state <= stExec;
          end
        end
        stExec: begin
          instr.execStrobe <= 1'b1;   // Single cycle pulse
          state            <= stExecWait;
        end
        stExecWait: begin
          instr.execStrobe <= 1'b0;
          if (instr.execDone) begin
            jumpPending <= instr.jumpTaken;
            jumpAddr    <= instr.jumpTarget;
            state       <= stUpdate;
          end
        end
        default: begin   // stUpdate
          instrPtr <= jumpPending ? jumpAddr : instrPtr + (longOp ? 32'd8 : 32'd4);
          state    <= stFetch;
        end
      endcase
    end
  end

  // RAM port strobes
  reqExclusive: assert property (@(posedge clk) disable iff (reset) !(readReq && writeReq));
  readPulse:    assert property (@(posedge clk) disable iff (reset) readReq |=> !readReq);
  writePulse:   assert property (@(posedge clk) disable iff (reset) writeReq |=> !writeReq);

endmodule

//--- verilog/regFile.sv
`timescale 1ns/100ps

module regFile (
  input  logic clk,
  input  logic reset,
  regIf.store  regs
);
  import cpuPkg::*;

  wordT mem [regCount];

  // Combinational reads
  assign regs.rdDataA = mem[regs.rdAddrA];
  assign regs.rdDataB = mem[regs.rdAddrB];
  assign regs.rdDataC = mem[regs.rdAddrC];
  assign regs.spValue = mem[spReg];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < regCount; i++) begin
        mem[i] <= '0;
      end
    end else begin
      if (regs.wrEn) begin
        mem[regs.wrAddr] <= regs.wrData;
      end
      // Later assignment wins, so SP port overrides a general write to r0
      if (regs.spWrEn) begin
        mem[spReg] <= regs.spData;
      end
    end
  end

  wrAddrKnown: assert property (@(posedge clk) disable iff (reset)
    regs.wrEn |-> !$isunknown(regs.wrAddr));

endmodule
